// ==== Bender.yml ====
package:
  name: int_pipe

sources:
  - source/int_pipe_pkg.sv
  - source/reg_file.sv
  - source/operand_forward.sv
  - source/issue_stage.sv
  - source/alu_exec.sv
  - source/result_pipe.sv
  - source/int_pipe_top.sv
  - target: test
    files:
      - testbench/int_pipe_tb.sv

// ==== list.f ====
source/int_pipe_pkg.sv
source/reg_file.sv
source/operand_forward.sv
source/issue_stage.sv
source/alu_exec.sv
source/result_pipe.sv
source/int_pipe_top.sv
testbench/int_pipe_tb.sv

// ==== source/alu_exec.sv ====
module alu_exec #(
    parameter int data_width = 64
) (
    input  int_pipe_pkg::alu_op_t ex_op,
    input  logic [data_width-1:0] ex_a,
    input  logic [data_width-1:0] ex_b,
    input  logic [data_width-1:0] ex_imm,
    output logic [data_width-1:0] ex_result
);

    import int_pipe_pkg::*;

    always_comb begin
        case (ex_op)
            op_add: begin
                ex_result = ex_a + ex_b;
            end
            op_sub: begin
                // Wraps modulo 2^data_width
                ex_result = ex_a - ex_b;
            end
            op_and: begin
                ex_result = ex_a & ex_b;
            end
            op_or: begin
                ex_result = ex_a | ex_b;
            end
            op_xor: begin
                ex_result = ex_a ^ ex_b;
            end
            op_li: begin
                ex_result = ex_imm;
            end
            default: begin
                ex_result = '0;
            end
        endcase
    end

endmodule

// ==== source/int_pipe_pkg.sv ====
package int_pipe_pkg;

    // Architectural register count, x0 included
    localparam int reg_count = 32;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Execute opcode
    typedef logic [2:0] alu_op_t;

    // Register-register operations
    localparam alu_op_t op_add = 3'd0;
    localparam alu_op_t op_sub = 3'd1;
    localparam alu_op_t op_and = 3'd2;
    localparam alu_op_t op_or  = 3'd3;
    localparam alu_op_t op_xor = 3'd4;

    // Load-immediate, result is the imm field
    localparam alu_op_t op_li  = 3'd5;

    // Codes 6 and 7 are unused and execute to zero

endpackage

// ==== source/int_pipe_top.sv ====
module int_pipe_top #(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  int_pipe_pkg::alu_op_t   op,
    input  int_pipe_pkg::reg_addr_t rd,
    input  int_pipe_pkg::reg_addr_t rs1,
    input  int_pipe_pkg::reg_addr_t rs2,
    input  logic [data_width-1:0]   imm,
    output logic                    wb_valid,
    output int_pipe_pkg::reg_addr_t wb_rd,
    output logic [data_width-1:0]   wb_data
);

    import int_pipe_pkg::*;

    // Issue cycle
    logic [data_width-1:0] rf_data1;
    logic [data_width-1:0] rf_data2;
    logic [data_width-1:0] opa;
    logic [data_width-1:0] opb;

    // EX stage
    logic                  ex_valid;
    alu_op_t               ex_op;
    reg_addr_t             ex_rd;
    logic [data_width-1:0] ex_a;
    logic [data_width-1:0] ex_b;
    logic [data_width-1:0] ex_imm;
    logic [data_width-1:0] ex_result;

    // MEM stage and register file write
    logic                  mem_valid;
    reg_addr_t             mem_rd;
    logic [data_width-1:0] mem_result;
    logic                  we;
    reg_addr_t             waddr;
    logic [data_width-1:0] wdata;

    issue_stage #(
        .data_width (data_width)
    ) issue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .op          (op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .opa         (opa),
        .opb         (opb),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_imm      (ex_imm)
    );

    reg_file #(
        .data_width (data_width)
    ) rf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    operand_forward #(
        .data_width (data_width)
    ) fwd_i (
        .rs1        (rs1),
        .rs2        (rs2),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .mem_valid  (mem_valid),
        .mem_rd     (mem_rd),
        .mem_result (mem_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .opa        (opa),
        .opb        (opb)
    );

    alu_exec #(
        .data_width (data_width)
    ) alu_i (
        .ex_op     (ex_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_imm    (ex_imm),
        .ex_result (ex_result)
    );

    result_pipe #(
        .data_width (data_width)
    ) res_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .mem_valid  (mem_valid),
        .mem_rd     (mem_rd),
        .mem_result (mem_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata)
    );

endmodule

// ==== source/issue_stage.sv ====
module issue_stage #(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  int_pipe_pkg::alu_op_t   op,
    input  int_pipe_pkg::reg_addr_t rd,
    input  int_pipe_pkg::reg_addr_t rs1,
    input  int_pipe_pkg::reg_addr_t rs2,
    input  logic [data_width-1:0]   imm,
    input  logic [data_width-1:0]   opa,
    input  logic [data_width-1:0]   opb,
    output logic                    ex_valid,
    output int_pipe_pkg::alu_op_t   ex_op,
    output int_pipe_pkg::reg_addr_t ex_rd,
    output logic [data_width-1:0]   ex_a,
    output logic [data_width-1:0]   ex_b,
    output logic [data_width-1:0]   ex_imm
);

    import int_pipe_pkg::*;

    // EX control, a bubble whenever issue_valid is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_op    <= op_add;
            ex_rd    <= '0;
        end else begin
            ex_valid <= issue_valid;
            ex_op    <= op;
            ex_rd    <= rd;
        end
    end

    // Resolved operands held for execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_a   <= '0;
            ex_b   <= '0;
            ex_imm <= '0;
        end else begin
            // x0 sources enter EX as zero whatever the read path returned
            if (rs1 == reg_addr_t'(0)) begin
                ex_a <= '0;
            end else begin
                ex_a <= opa;
            end
            if (rs2 == reg_addr_t'(0)) begin
                ex_b <= '0;
            end else begin
                ex_b <= opb;
            end
            ex_imm <= imm;
        end
    end

endmodule

// ==== source/operand_forward.sv ====
module operand_forward #(
    parameter int data_width = 64
) (
    input  int_pipe_pkg::reg_addr_t rs1,
    input  int_pipe_pkg::reg_addr_t rs2,
    input  logic [data_width-1:0]   rf_data1,
    input  logic [data_width-1:0]   rf_data2,
    input  logic                    ex_valid,
    input  int_pipe_pkg::reg_addr_t ex_rd,
    input  logic [data_width-1:0]   ex_result,
    input  logic                    mem_valid,
    input  int_pipe_pkg::reg_addr_t mem_rd,
    input  logic [data_width-1:0]   mem_result,
    input  logic                    wb_valid,
    input  int_pipe_pkg::reg_addr_t wb_rd,
    input  logic [data_width-1:0]   wb_data,
    output logic [data_width-1:0]   opa,
    output logic [data_width-1:0]   opb
);

    import int_pipe_pkg::*;

    // Stage holds a pending write to the requested register
    function automatic logic hit(
        input logic      valid,
        input reg_addr_t rd,
        input reg_addr_t rs
    );
        return valid && (rd == rs) && (rs != reg_addr_t'(0));
    endfunction

    // Youngest in-flight result wins, register file last
    function automatic logic [data_width-1:0] pick(
        input reg_addr_t             rs,
        input logic [data_width-1:0] rf_val
    );
        logic [data_width-1:0] val;
        if (hit(ex_valid, ex_rd, rs)) begin
            val = ex_result;
        end else if (hit(mem_valid, mem_rd, rs)) begin
            val = mem_result;
        end else if (hit(wb_valid, wb_rd, rs)) begin
            // Register file write for this entry lands one edge later
            val = wb_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // Each operand resolves on its own, so both may forward from different stages
    always_comb begin
        opa = pick(rs1, rf_data1);
        opb = pick(rs2, rf_data2);
    end

endmodule

// ==== source/reg_file.sv ====
module reg_file #(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  int_pipe_pkg::reg_addr_t raddr1,
    input  int_pipe_pkg::reg_addr_t raddr2,
    output logic [data_width-1:0]   rdata1,
    output logic [data_width-1:0]   rdata2,
    input  logic                    we,
    input  int_pipe_pkg::reg_addr_t waddr,
    input  logic [data_width-1:0]   wdata
);

    import int_pipe_pkg::*;

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != reg_addr_t'(0))) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous read, x0 forced to zero
    always_comb begin
        if (raddr1 == reg_addr_t'(0)) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == reg_addr_t'(0)) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== source/result_pipe.sv ====
module result_pipe #(
    parameter int data_width = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ex_valid,
    input  int_pipe_pkg::reg_addr_t ex_rd,
    input  logic [data_width-1:0]   ex_result,
    output logic                    mem_valid,
    output int_pipe_pkg::reg_addr_t mem_rd,
    output logic [data_width-1:0]   mem_result,
    output logic                    wb_valid,
    output int_pipe_pkg::reg_addr_t wb_rd,
    output logic [data_width-1:0]   wb_data,
    output logic                    we,
    output int_pipe_pkg::reg_addr_t waddr,
    output logic [data_width-1:0]   wdata
);

    import int_pipe_pkg::*;

    // MEM and WB control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_rd    <= '0;
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
        end else begin
            mem_valid <= ex_valid;
            mem_rd    <= ex_rd;
            wb_valid  <= mem_valid;
            wb_rd     <= mem_rd;
        end
    end

    // Result payload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_result <= '0;
            wb_data    <= '0;
        end else begin
            mem_result <= ex_result;
            wb_data    <= mem_result;
        end
    end

    // Register file samples the WB entry at the next edge
    // x0 targets still pulse wb_valid but never write
    always_comb begin
        we    = wb_valid && (wb_rd != reg_addr_t'(0));
        waddr = wb_rd;
        wdata = wb_data;
    end

endmodule

// ==== testbench/int_pipe_tb.sv ====
module int_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import int_pipe_pkg::*;

    localparam int data_width   = 64;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;
    localparam int max_rows     = 128;
    localparam int n_random     = 48;

    typedef logic [data_width-1:0] data_t;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    alu_op_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;

    // Instruction table with expected write-back values
    alu_op_t   row_op  [max_rows];
    reg_addr_t row_rd  [max_rows];
    reg_addr_t row_rs1 [max_rows];
    reg_addr_t row_rs2 [max_rows];
    data_t     row_imm [max_rows];
    int        row_gap [max_rows];
    data_t     row_exp [max_rows];
    int        row_count;
    int        n_directed;

    data_t model_regs [reg_count];

    // Results in flight, oldest first
    data_t     pend_data_q  [$];
    reg_addr_t pend_rd_q    [$];
    int        pend_cycle_q [$];
    int        pend_row_q   [$];

    int cycle_count;
    int pulse_count;
    int ok_count;
    int bad_count;
    int error_count;

    int_pipe_top #(
        .data_width (data_width)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .op          (op),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .imm         (imm),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ALU rules, unknown opcodes give zero
    function automatic data_t expected_result(
        input alu_op_t o,
        input data_t   a,
        input data_t   b,
        input data_t   i
    );
        case (o)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_li:   return i;
            default: return '0;
        endcase
    endfunction

    task automatic add_row(
        input alu_op_t   o,
        input reg_addr_t d,
        input reg_addr_t s1,
        input reg_addr_t s2,
        input data_t     i,
        input int        gap,
        input data_t     e
    );
        row_op[row_count]  = o;
        row_rd[row_count]  = d;
        row_rs1[row_count] = s1;
        row_rs2[row_count] = s2;
        row_imm[row_count] = i;
        row_gap[row_count] = gap;
        row_exp[row_count] = e;
        row_count++;
    endtask

    task automatic build_table();
        logic [63:0] wide;
        // Reset state and spaced register-file results
        add_row(op_add, 1, 0, 0, 0, 3, 0);
        add_row(op_li,  1, 0, 0, 64'h1234_5678_0000_00f0, 3, 64'h1234_5678_0000_00f0);
        add_row(op_li,  2, 0, 0, 64'h00ff_0000_0000_0f0f, 3, 64'h00ff_0000_0000_0f0f);
        add_row(op_add, 3, 1, 2, 0, 3, 64'h1333_5678_0000_0fff);
        add_row(op_sub, 4, 2, 1, 0, 3, 64'heeca_a988_0000_0e1f);
        add_row(op_and, 5, 1, 2, 0, 3, 64'h0034_0000_0000_0000);
        add_row(op_or,  6, 1, 2, 0, 3, 64'h12ff_5678_0000_0fff);
        add_row(op_xor, 7, 1, 2, 0, 3, 64'h12cb_5678_0000_0fff);
        // Back to back, EX and MEM forwarding
        add_row(op_li,  8, 0, 0, 5, 0, 5);
        add_row(op_add, 9, 8, 8, 0, 0, 10);
        add_row(op_sub, 10, 9, 8, 0, 0, 5);
        add_row(op_xor, 11, 10, 9, 0, 3, 15);
        // Distances 2 and 3
        add_row(op_li,  12, 0, 0, 'h100, 0, 'h100);
        add_row(op_li,  13, 0, 0, 'h011, 0, 'h011);
        add_row(op_add, 14, 12, 13, 0, 0, 'h111);
        add_row(op_and, 15, 14, 12, 0, 3, 'h100);
        // Two pending writes to x16, youngest wins
        add_row(op_li,  16, 0, 0, 'haa, 0, 'haa);
        add_row(op_li,  16, 0, 0, 'h55, 0, 'h55);
        add_row(op_add, 17, 16, 0, 0, 0, 'h55);
        add_row(op_add, 18, 16, 16, 0, 0, 'haa);
        add_row(op_or,  19, 16, 17, 0, 3, 'h55);
        // x0 write is shown at WB but never forwarded or stored
        add_row(op_li,  0, 0, 0, 'h77, 0, 'h77);
        add_row(op_add, 20, 0, 0, 0, 0, 0);
        add_row(op_or,  21, 0, 0, 0, 0, 0);
        add_row(op_add, 22, 0, 0, 0, 0, 0);
        add_row(op_xor, 23, 0, 8, 0, 3, 5);
        n_directed = row_count;
        // Small register window keeps hazards frequent
        for (int k = 0; k < n_random; k++) begin
            wide = {$urandom(), $urandom()};
            add_row(alu_op_t'($urandom_range(7)), reg_addr_t'($urandom_range(7)),
                    reg_addr_t'($urandom_range(7)), reg_addr_t'($urandom_range(7)),
                    wide[data_width-1:0], $urandom_range(3), '0);
        end
    endtask

    // Program-order register model fills in the random rows
    task automatic run_model();
        data_t val;
        for (int r = 0; r < row_count; r++) begin
            val = expected_result(row_op[r], model_regs[row_rs1[r]],
                                  model_regs[row_rs2[r]], row_imm[r]);
            if (r >= n_directed) begin
                row_exp[r] = val;
            end else if (val !== row_exp[r]) begin
                $display("Table row %0d expects %h but the register model gives %h",
                         r, row_exp[r], val);
                error_count++;
            end
            if (row_rd[r] != reg_addr_t'(0)) begin
                model_regs[row_rd[r]] = val;
            end
        end
    endtask

    task automatic check_data(input int row, input data_t got, input data_t exp, inout bit ok);
        if (got !== exp) begin
            $display("FAILED at %0d ns: row %0d wb_data is %h, expected %h",
                     $time, row, got, exp);
            error_count++;
            ok = 1'b0;
        end
    endtask

    task automatic check_addr(input int row, input reg_addr_t got, input reg_addr_t exp,
                              inout bit ok);
        if (got !== exp) begin
            $display("FAILED at %0d ns: row %0d wb_rd is %0d, expected %0d",
                     $time, row, got, exp);
            error_count++;
            ok = 1'b0;
        end
    endtask

    // Write-back monitor, sampled mid-cycle
    always @(negedge clk) begin
        int        row;
        data_t     exp_data;
        reg_addr_t exp_rd;
        int        exp_cycle;
        bit        ok;
        if (rst_n && wb_valid === 1'b1) begin
            pulse_count++;
            if (pend_data_q.size() == 0) begin
                $display("Extra wb_valid pulse at %0d ns with no instruction outstanding",
                         $time);
                error_count++;
            end else begin
                exp_data  = pend_data_q.pop_front();
                exp_rd    = pend_rd_q.pop_front();
                exp_cycle = pend_cycle_q.pop_front();
                row       = pend_row_q.pop_front();
                ok        = 1'b1;
                if (cycle_count != exp_cycle) begin
                    $display("FAILED at %0d ns: row %0d written back in cycle %0d, expected %0d",
                             $time, row, cycle_count, exp_cycle);
                    error_count++;
                    ok = 1'b0;
                end
                check_addr(row, wb_rd, exp_rd, ok);
                check_data(row, wb_data, exp_data, ok);
                if (ok) begin
                    ok_count++;
                    $display("Row %0d: x%0d = %h ok", row, exp_rd, exp_data);
                end else begin
                    bad_count++;
                    $display("Row %0d: mismatch", row);
                end
            end
        end else if (rst_n && pend_cycle_q.size() != 0 && pend_cycle_q[0] <= cycle_count) begin
            row = pend_row_q.pop_front();
            void'(pend_data_q.pop_front());
            void'(pend_rd_q.pop_front());
            void'(pend_cycle_q.pop_front());
            $display("Row %0d: no wb_valid pulse two edges after issue", row);
            bad_count++;
            error_count++;
        end
    end

    initial begin
        int slots;
        int slot;
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        op          = op_add;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        cycle_count = 0;
        pulse_count = 0;
        ok_count    = 0;
        bad_count   = 0;
        error_count = 0;
        row_count   = 0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(62677));
        build_table();
        run_model();

        slots = 0;
        for (int r = 0; r < row_count; r++) begin
            slots += 1 + row_gap[r];
        end
        fork
            begin
                #((reset_cycles + slots + 20) * clk_period);
                $display("Timeout at %0d ns with %0d results outstanding",
                         $time, pend_data_q.size());
                $display("Simulation failed");
                $finish;
            end
        join_none

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (wb_valid !== 1'b0) begin
            $display("FAILED at %0d ns: wb_valid is not low after reset", $time);
            error_count++;
        end

        for (int r = 0; r < row_count; r++) begin
            @(negedge clk);
            issue_valid = 1'b1;
            op          = row_op[r];
            rd          = row_rd[r];
            rs1         = row_rs1[r];
            rs2         = row_rs2[r];
            imm         = row_imm[r];
            slot        = cycle_count + 1;
            @(posedge clk);
            pend_data_q.push_back(row_exp[r]);
            pend_rd_q.push_back(row_rd[r]);
            pend_cycle_q.push_back(slot + 2);
            pend_row_q.push_back(r);
            for (int g = 0; g < row_gap[r]; g++) begin
                @(negedge clk);
                issue_valid = 1'b0;
            end
        end
        @(negedge clk);
        issue_valid = 1'b0;

        while (pend_data_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        @(posedge clk);

        if (pulse_count != row_count) begin
            $display("Issued %0d instructions but counted %0d wb_valid pulses",
                     row_count, pulse_count);
            error_count++;
        end
        $display("%0d tests, %0d ok, %0d failed, %0d errors",
                 row_count, ok_count, bad_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
